//--- sources.f
src/kv_defines_pkg.sv
src/kv_fsm.sv
src/kv_write_client.sv
src/kv_write_arbiter.sv
src/kv_store.sv
src/kv_top.sv
tb/kv_sva.sv
tb/kv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= kv_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -Wno-fatal
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/kv_tb.sv
`timescale 1ns/10ps
`default_nettype none

module kv_tb;

    import kv_defines_pkg::*;

    localparam int DATA_WIDTH = 384;
    localparam int NUM_CLIENTS = 2;
    localparam int NUM_DW = DATA_WIDTH / 32;
    localparam int NUM_ROWS = 6;
    localparam int CYCLE_LIMIT = NUM_ROWS * 64 + 100;

    // one table row, entry2 and pcr2 only used when both clients run
    typedef struct packed {
        logic [1:0]             mask;
        logic [KV_ENTRY_W-1:0]  entry;
        logic                   pcr;
        logic [KV_NUM_DEST-1:0] dv;
        logic                   lock;
        logic [KV_ENTRY_W-1:0]  entry2;
        logic                   pcr2;
    } row_t;

    logic                                     clk;
    logic                                     rst_n;
    logic [NUM_CLIENTS-1:0]                   ctrl_we;
    kv_write_ctrl_reg_u [NUM_CLIENTS-1:0]     ctrl_wdata;
    logic [NUM_CLIENTS-1:0]                   dest_data_avail;
    logic [NUM_CLIENTS-1:0][NUM_DW-1:0][31:0] dest_data;
    logic [NUM_CLIENTS-1:0]                   dest_keyvault;
    logic [NUM_CLIENTS-1:0]                   dest_done;
    logic                                     lock_we;
    logic [KV_ENTRY_W-1:0]                    lock_entry;
    logic                                     lock_is_pcr;
    logic                                     lock_val;
    logic                                     rd_is_pcr;
    logic [KV_ENTRY_W-1:0]                    rd_entry;
    logic [KV_OFFSET_W-1:0]                   rd_offset;
    logic [31:0]                              rd_data;
    logic [KV_NUM_DEST-1:0]                   rd_dest_valid;

    // reference vault, bank 0 key, bank 1 pcr
    logic [31:0]            ref_mem [2][KV_NUM_ENTRIES][KV_ENTRY_DWORDS];
    logic [KV_NUM_DEST-1:0] ref_dv [2][KV_NUM_ENTRIES];
    logic                   ref_lock [2][KV_NUM_ENTRIES];

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;
    int          cycle_cnt;
    int          err_cnt;

    kv_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_CLIENTS(NUM_CLIENTS)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_we        (ctrl_we),
        .ctrl_wdata     (ctrl_wdata),
        .dest_data_avail(dest_data_avail),
        .dest_data      (dest_data),
        .dest_keyvault  (dest_keyvault),
        .dest_done      (dest_done),
        .lock_we        (lock_we),
        .lock_entry     (lock_entry),
        .lock_is_pcr    (lock_is_pcr),
        .lock_val       (lock_val),
        .rd_is_pcr      (rd_is_pcr),
        .rd_entry       (rd_entry),
        .rd_offset      (rd_offset),
        .rd_data        (rd_data),
        .rd_dest_valid  (rd_dest_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit from the table length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $fatal(1, "cycle limit reached");
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per payload bit
    task automatic random_dword(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_next(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            err_cnt = err_cnt + 1;
            $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "first mismatch");
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_table();
        // single client, key then pcr on the same entry number
        rows[0] = '{2'b01, 3'd3, 1'b0, 6'h15, 1'b0, 3'd0, 1'b0};
        rows[1] = '{2'b01, 3'd3, 1'b1, 6'h2a, 1'b0, 3'd0, 1'b0};
        // locked write dropped, then unlocked repeat
        rows[2] = '{2'b10, 3'd3, 1'b0, 6'h3f, 1'b1, 3'd0, 1'b0};
        rows[3] = '{2'b10, 3'd3, 1'b0, 6'h07, 1'b0, 3'd0, 1'b0};
        // both clients in the same cycle
        rows[4] = '{2'b11, 3'd5, 1'b0, 6'h19, 1'b0, 3'd1, 1'b1};
        rows[5] = '{2'b11, 3'd0, 1'b1, 6'h2c, 1'b0, 3'd3, 1'b0};
    endtask

    // both banks of one entry number, every offset
    task automatic sweep_entry(input logic [KV_ENTRY_W-1:0] e);
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < KV_ENTRY_DWORDS; k++) begin
                next_cycle();
                rd_is_pcr = b[0];
                rd_entry  = e;
                rd_offset = KV_OFFSET_W'(k);
                @(negedge clk);
                check_value($sformatf("rd_data[%0d][%0d][%0d]", b, e, k), rd_data,
                            ref_mem[b][e][k]);
                if (k == 0) begin
                    check_value("rd_dest_valid", 32'(rd_dest_valid), 32'(ref_dv[b][e]));
                end
            end
        end
    endtask

    task automatic run_row(input row_t row);
        logic [KV_ENTRY_W-1:0]  ent [NUM_CLIENTS];
        logic                   pcr [NUM_CLIENTS];
        logic [KV_NUM_DEST-1:0] dv [NUM_CLIENTS];
        logic [NUM_CLIENTS-1:0] pending;
        logic [31:0]            w;
        kv_write_ctrl_reg_u     cw;
        int                     f;
        // client 1 takes the second target and inverted dest bits when both run
        ent[0] = row.entry;
        pcr[0] = row.pcr;
        dv[0]  = row.dv;
        ent[1] = (row.mask == 2'b11) ? row.entry2 : row.entry;
        pcr[1] = (row.mask == 2'b11) ? row.pcr2 : row.pcr;
        dv[1]  = (row.mask == 2'b11) ? ~row.dv : row.dv;
        f = row.mask[0] ? 0 : 1;
        next_cycle();
        // lock or unlock the first target when needed
        if (row.lock || ref_lock[pcr[f]][ent[f]]) begin
            lock_we     = 1'b1;
            lock_is_pcr = pcr[f];
            lock_entry  = ent[f];
            lock_val    = row.lock;
            ref_lock[pcr[f]][ent[f]] = row.lock;
        end
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            cw.raw                = '0;
            cw.fld.write_en       = 1'b1;
            cw.fld.write_entry    = ent[c];
            cw.fld.entry_is_pcr   = pcr[c];
            cw.fld.write_dest_vld = dv[c];
            ctrl_wdata[c]         = cw;
            for (int d = 0; d < NUM_DW; d++) begin
                random_dword(w);
                dest_data[c][d] = w;
            end
        end
        ctrl_we = row.mask;
        next_cycle();
        ctrl_we         = '0;
        lock_we         = 1'b0;
        dest_data_avail = row.mask;
        @(negedge clk);
        check_value("dest_keyvault", 32'(dest_keyvault), 32'(row.mask));
        // every started client must pulse done, idle ones never
        pending = row.mask;
        while (pending != '0) begin
            @(negedge clk);
            check_value("dest_done_idle", 32'(dest_done & ~row.mask), 32'd0);
            pending = pending & ~dest_done;
        end
        // expected vault, msb dword lands at offset 0
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (row.mask[c] && !ref_lock[pcr[c]][ent[c]]) begin
                for (int k = 0; k < NUM_DW; k++) begin
                    ref_mem[pcr[c]][ent[c]][k] = dest_data[c][NUM_DW-1-k];
                end
                ref_dv[pcr[c]][ent[c]] = dv[c];
            end
        end
        next_cycle();
        dest_data_avail = '0;
        @(negedge clk);
        // write_en cleared itself
        check_value("dest_keyvault", 32'(dest_keyvault), 32'd0);
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (row.mask[c]) begin
                sweep_entry(ent[c]);
            end
        end
    endtask

    // control word with write_en low must never start a copy
    task automatic check_no_start();
        kv_write_ctrl_reg_u cw;
        next_cycle();
        cw.raw        = 32'h0000_07e6;
        ctrl_wdata[0] = cw;
        ctrl_we       = 2'b01;
        next_cycle();
        ctrl_we         = '0;
        dest_data_avail = 2'b01;
        repeat (2 * NUM_DW + 6) begin
            @(negedge clk);
            check_value("dest_done", 32'(dest_done), 32'd0);
            check_value("dest_keyvault", 32'(dest_keyvault), 32'd0);
        end
        next_cycle();
        dest_data_avail = '0;
        rd_is_pcr       = 1'b0;
        rd_entry        = 3'd3;
        rd_offset       = '0;
        @(negedge clk);
        check_value("rd_data", rd_data, ref_mem[0][3][0]);
        check_value("rd_dest_valid", 32'(rd_dest_valid), 32'(ref_dv[0][3]));
    endtask

    initial begin
        lfsr            = 16'd34;
        err_cnt         = 0;
        rst_n           = 1'b0;
        ctrl_we         = '0;
        ctrl_wdata      = '0;
        dest_data_avail = '0;
        dest_data       = '0;
        lock_we         = 1'b0;
        lock_entry      = '0;
        lock_is_pcr     = 1'b0;
        lock_val        = 1'b0;
        rd_is_pcr       = 1'b0;
        rd_entry        = '0;
        rd_offset       = '0;
        for (int b = 0; b < 2; b++) begin
            for (int e = 0; e < KV_NUM_ENTRIES; e++) begin
                ref_dv[b][e]   = '0;
                ref_lock[b][e] = 1'b0;
                for (int k = 0; k < KV_ENTRY_DWORDS; k++) begin
                    ref_mem[b][e][k] = '0;
                end
            end
        end
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        // quiet after reset, vault empty
        check_value("dest_done", 32'(dest_done), 32'd0);
        check_value("dest_keyvault", 32'(dest_keyvault), 32'd0);
        check_value("rd_data", rd_data, 32'd0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        check_no_start();
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/kv_sva.sv
`timescale 1ns/10ps
`default_nettype none

module kv_sva #(
    parameter int NUM_CLIENTS = 2
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic [NUM_CLIENTS-1:0] req,
    input logic [NUM_CLIENTS-1:0] grant,
    input logic                   kv_write_en
);

    // at most one client owns the port
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    // a waiting request has the port in the same cycle, no idle handover
    a_write_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (req != '0) |-> (kv_write_en && ((grant & req) != '0)))
        else $error("a client requested but the vault port was idle");

    // burst lock, owner keeps the port while its req holds
    a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (($past(grant) & $past(req) & req) != '0) |-> (grant == $past(grant)))
        else $error("grant moved while the owner still requested");

    // no grant until somebody asks
    a_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (grant != '0) |-> (req != '0))
        else $error("grant high with no request");

endmodule

bind kv_write_arbiter kv_sva #(
    .NUM_CLIENTS(NUM_CLIENTS)
) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .grant      (grant),
    .kv_write_en(kv_write_en)
);

`default_nettype wire

//--- src/kv_top.sv
`timescale 1ns/10ps
`default_nettype none

module kv_top #(
    parameter int DATA_WIDTH = 384,
    parameter int NUM_CLIENTS = 2,
    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    // per client control and result ports
    input  logic [NUM_CLIENTS-1:0]                                 ctrl_we,
    input  kv_defines_pkg::kv_write_ctrl_reg_u [NUM_CLIENTS-1:0]   ctrl_wdata,
    input  logic [NUM_CLIENTS-1:0]                                 dest_data_avail,
    input  logic [NUM_CLIENTS-1:0][DATA_NUM_DWORDS-1:0][31:0]      dest_data,
    output logic [NUM_CLIENTS-1:0]                                 dest_keyvault,
    output logic [NUM_CLIENTS-1:0]                                 dest_done,
    // lock control
    input  logic                                                   lock_we,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]                  lock_entry,
    input  logic                                                   lock_is_pcr,
    input  logic                                                   lock_val,
    // read port
    input  logic                                                   rd_is_pcr,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]                  rd_entry,
    input  logic [kv_defines_pkg::KV_OFFSET_W-1:0]                 rd_offset,
    output logic [31:0]                                            rd_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0]                 rd_dest_valid
);

    import kv_defines_pkg::*;

    // client to arbiter
    logic [NUM_CLIENTS-1:0]                  req;
    logic [NUM_CLIENTS-1:0]                  grant;
    logic [NUM_CLIENTS-1:0]                  wr_entry_is_pcr;
    logic [NUM_CLIENTS-1:0][KV_ENTRY_W-1:0]  wr_entry;
    logic [NUM_CLIENTS-1:0][KV_OFFSET_W-1:0] wr_offset;
    logic [NUM_CLIENTS-1:0][31:0]            wr_data;
    logic [NUM_CLIENTS-1:0][KV_NUM_DEST-1:0] wr_dest_valid;

    // arbiter to store
    logic                   kv_write_en;
    logic                   kv_entry_is_pcr;
    logic [KV_ENTRY_W-1:0]  kv_write_entry;
    logic [KV_OFFSET_W-1:0] kv_write_offset;
    logic [31:0]            kv_write_data;
    logic [KV_NUM_DEST-1:0] kv_write_dest_valid;

    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_client
        kv_write_client #(
            .DATA_WIDTH(DATA_WIDTH)
        ) u_client (
            .clk            (clk),
            .rst_n          (rst_n),
            .ctrl_we        (ctrl_we[i]),
            .ctrl_wdata     (ctrl_wdata[i]),
            .dest_data_avail(dest_data_avail[i]),
            .dest_data      (dest_data[i]),
            .dest_keyvault  (dest_keyvault[i]),
            .dest_done      (dest_done[i]),
            .grant          (grant[i]),
            .req            (req[i]),
            .wr_entry_is_pcr(wr_entry_is_pcr[i]),
            .wr_entry       (wr_entry[i]),
            .wr_offset      (wr_offset[i]),
            .wr_data        (wr_data[i]),
            .wr_dest_valid  (wr_dest_valid[i])
        );
    end

    kv_write_arbiter #(
        .NUM_CLIENTS(NUM_CLIENTS)
    ) u_arbiter (
        .clk                (clk),
        .rst_n              (rst_n),
        .req                (req),
        .wr_entry_is_pcr    (wr_entry_is_pcr),
        .wr_entry           (wr_entry),
        .wr_offset          (wr_offset),
        .wr_data            (wr_data),
        .wr_dest_valid      (wr_dest_valid),
        .grant              (grant),
        .kv_write_en        (kv_write_en),
        .kv_entry_is_pcr    (kv_entry_is_pcr),
        .kv_write_entry     (kv_write_entry),
        .kv_write_offset    (kv_write_offset),
        .kv_write_data      (kv_write_data),
        .kv_write_dest_valid(kv_write_dest_valid)
    );

    kv_store u_store (
        .clk                (clk),
        .rst_n              (rst_n),
        .kv_write_en        (kv_write_en),
        .kv_entry_is_pcr    (kv_entry_is_pcr),
        .kv_write_entry     (kv_write_entry),
        .kv_write_offset    (kv_write_offset),
        .kv_write_data      (kv_write_data),
        .kv_write_dest_valid(kv_write_dest_valid),
        .lock_we            (lock_we),
        .lock_is_pcr        (lock_is_pcr),
        .lock_entry         (lock_entry),
        .lock_val           (lock_val),
        .rd_is_pcr          (rd_is_pcr),
        .rd_entry           (rd_entry),
        .rd_offset          (rd_offset),
        .rd_data            (rd_data),
        .rd_dest_valid      (rd_dest_valid)
    );

endmodule

`default_nettype wire

//--- src/kv_store.sv
`timescale 1ns/10ps
`default_nettype none

module kv_store (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // write port from the arbiter
    input  logic                                   kv_write_en,
    input  logic                                   kv_entry_is_pcr,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]  kv_write_entry,
    input  logic [kv_defines_pkg::KV_OFFSET_W-1:0] kv_write_offset,
    input  logic [31:0]                            kv_write_data,
    input  logic [kv_defines_pkg::KV_NUM_DEST-1:0] kv_write_dest_valid,
    // lock control
    input  logic                                   lock_we,
    input  logic                                   lock_is_pcr,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]  lock_entry,
    input  logic                                   lock_val,
    // read port
    input  logic                                   rd_is_pcr,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0]  rd_entry,
    input  logic [kv_defines_pkg::KV_OFFSET_W-1:0] rd_offset,
    output logic [31:0]                            rd_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0] rd_dest_valid
);

    import kv_defines_pkg::*;

    // bank 0 key, bank 1 pcr
    logic [1:0][KV_NUM_ENTRIES-1:0][KV_ENTRY_DWORDS-1:0][31:0] mem;
    logic [1:0][KV_NUM_ENTRIES-1:0][KV_NUM_DEST-1:0]           dest_vld;
    logic [1:0][KV_NUM_ENTRIES-1:0]                            lock;
    // write accepted this cycle
    logic                                                      wr_ok;

    // locked entries drop the write without a response
    assign wr_ok = kv_write_en & ~lock[kv_entry_is_pcr][kv_write_entry];

    // entry payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem <= '0;
        end else if (wr_ok) begin
            mem[kv_entry_is_pcr][kv_write_entry][kv_write_offset] <= kv_write_data;
        end
    end

    // dest valid bits
    // loaded once per entry write, with dword 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_vld <= '0;
        end else if (wr_ok && (kv_write_offset == '0)) begin
            dest_vld[kv_entry_is_pcr][kv_write_entry] <= kv_write_dest_valid;
        end
    end

    // per entry lock bits, set or cleared one at a time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock <= '0;
        end else if (lock_we) begin
            lock[lock_is_pcr][lock_entry] <= lock_val;
        end
    end

    // combinational read
    assign rd_data       = mem[rd_is_pcr][rd_entry][rd_offset];
    assign rd_dest_valid = dest_vld[rd_is_pcr][rd_entry];

endmodule

`default_nettype wire

//--- src/kv_write_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module kv_write_arbiter #(
    parameter int NUM_CLIENTS = 2,
    localparam int OWNER_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    // one slot per client
    input  logic [NUM_CLIENTS-1:0]                                  req,
    input  logic [NUM_CLIENTS-1:0]                                  wr_entry_is_pcr,
    input  logic [NUM_CLIENTS-1:0][kv_defines_pkg::KV_ENTRY_W-1:0]  wr_entry,
    input  logic [NUM_CLIENTS-1:0][kv_defines_pkg::KV_OFFSET_W-1:0] wr_offset,
    input  logic [NUM_CLIENTS-1:0][31:0]                            wr_data,
    input  logic [NUM_CLIENTS-1:0][kv_defines_pkg::KV_NUM_DEST-1:0] wr_dest_valid,
    output logic [NUM_CLIENTS-1:0]                                  grant,
    // shared vault write port
    output logic                                                    kv_write_en,
    output logic                                                    kv_entry_is_pcr,
    output logic [kv_defines_pkg::KV_ENTRY_W-1:0]                   kv_write_entry,
    output logic [kv_defines_pkg::KV_OFFSET_W-1:0]                  kv_write_offset,
    output logic [31:0]                                             kv_write_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0]                  kv_write_dest_valid
);

    // port held by last_owner during a burst
    logic               owner_vld;
    logic [OWNER_W-1:0] last_owner;
    // this cycle's decision
    logic               sel_vld;
    logic [OWNER_W-1:0] sel;

    always_comb begin
        int idx;
        idx     = 0;
        sel_vld = 1'b0;
        sel     = last_owner;
        if (owner_vld && req[last_owner]) begin
            // burst lock, owner keeps the port until its req falls
            sel_vld = 1'b1;
        end else begin
            // round robin, start one past the last owner
            for (int i = 1; i <= NUM_CLIENTS; i++) begin
                idx = (int'(last_owner) + i) % NUM_CLIENTS;
                if (!sel_vld && req[idx]) begin
                    sel_vld = 1'b1;
                    sel     = OWNER_W'(idx);
                end
            end
        end
    end

    always_comb begin
        grant      = '0;
        grant[sel] = sel_vld;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_vld  <= 1'b0;
            // client 0 gets first pick
            last_owner <= OWNER_W'(NUM_CLIENTS - 1);
        end else begin
            owner_vld <= sel_vld;
            if (sel_vld) begin
                last_owner <= sel;
            end
        end
    end

    // granted client's fields onto the port
    assign kv_write_en         = |(grant & req);
    assign kv_entry_is_pcr     = wr_entry_is_pcr[sel];
    assign kv_write_entry      = wr_entry[sel];
    assign kv_write_offset     = wr_offset[sel];
    assign kv_write_data       = wr_data[sel];
    assign kv_write_dest_valid = wr_dest_valid[sel];

endmodule

`default_nettype wire

//--- src/kv_write_client.sv
`timescale 1ns/10ps
`default_nettype none

module kv_write_client #(
    parameter int DATA_WIDTH = 384,
    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32,
    localparam int DATA_OFFSET_W = (DATA_NUM_DWORDS > 1) ? $clog2(DATA_NUM_DWORDS) : 1
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // software control word
    input  logic                                   ctrl_we,
    input  kv_defines_pkg::kv_write_ctrl_reg_u     ctrl_wdata,
    // result side
    input  logic                                   dest_data_avail,
    input  logic [DATA_NUM_DWORDS-1:0][31:0]       dest_data,
    output logic                                   dest_keyvault,
    output logic                                   dest_done,
    // write port towards the arbiter
    input  logic                                   grant,
    output logic                                   req,
    output logic                                   wr_entry_is_pcr,
    output logic [kv_defines_pkg::KV_ENTRY_W-1:0]  wr_entry,
    output logic [kv_defines_pkg::KV_OFFSET_W-1:0] wr_offset,
    output logic [31:0]                            wr_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0] wr_dest_valid
);

    import kv_defines_pkg::*;

    kv_write_ctrl_reg_u       ctrl_reg;
    logic [DATA_OFFSET_W-1:0] read_offset;
    logic                     start;
    logic                     busy;

    // busy from req up to the end of the done pulse
    assign busy = req | dest_done;

    // kick the sequencer once per armed write
    assign start = ctrl_reg.fld.write_en & dest_data_avail & ~busy;

    // control word, loaded whole, write_en drops after done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_reg.raw <= '0;
        end else if (dest_done) begin
            ctrl_reg.fld.write_en <= 1'b0;
        end else if (ctrl_we && !busy) begin
            ctrl_reg.raw <= ctrl_wdata.raw;
        end
    end

    kv_fsm #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_dest_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .grant       (grant),
        .req         (req),
        .read_offset (read_offset),
        .write_offset(wr_offset),
        .done        (dest_done)
    );

    // tells the result side the vault is taking its output
    assign dest_keyvault = ctrl_reg.fld.write_en;

    // entry target comes straight from the fields
    assign wr_entry_is_pcr = ctrl_reg.fld.entry_is_pcr;
    assign wr_entry        = ctrl_reg.fld.write_entry;
    assign wr_dest_valid   = ctrl_reg.fld.write_dest_vld;

    // most significant dword goes out first
    assign wr_data = dest_data[DATA_OFFSET_W'(DATA_NUM_DWORDS - 1) - read_offset];

endmodule

`default_nettype wire

//--- src/kv_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module kv_fsm #(
    parameter int DATA_WIDTH = 384,
    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32,
    localparam int DATA_OFFSET_W = (DATA_NUM_DWORDS > 1) ? $clog2(DATA_NUM_DWORDS) : 1
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  logic                                   grant,
    output logic                                   req,
    output logic [DATA_OFFSET_W-1:0]               read_offset,
    output logic [kv_defines_pkg::KV_OFFSET_W-1:0] write_offset,
    output logic                                   done
);

    // state bit, low is idle, high is busy
    logic busy;
    // final dword accepted this cycle
    logic last_dword;

    // request is simply the busy state
    assign req = busy;

    assign last_dword = busy && grant &&
                        (read_offset == DATA_OFFSET_W'(DATA_NUM_DWORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            read_offset  <= '0;
            write_offset <= '0;
            done         <= 1'b0;
        end else begin
            // one-cycle pulse after the last write
            done <= last_dword;
            if (!busy) begin
                // offsets sit at zero while idle
                if (start) begin
                    busy <= 1'b1;
                end
            end else if (grant) begin
                if (last_dword) begin
                    // back to idle, ready for the next entry
                    busy         <= 1'b0;
                    read_offset  <= '0;
                    write_offset <= '0;
                end else begin
                    // both sides step together on a granted cycle
                    read_offset  <= read_offset + DATA_OFFSET_W'(1);
                    write_offset <= write_offset + kv_defines_pkg::KV_OFFSET_W'(1);
                end
            end
            // no grant, offsets hold
        end
    end

endmodule

`default_nettype wire

//--- src/kv_defines_pkg.sv
`default_nettype none

package kv_defines_pkg;

    // entries in each bank, key and pcr alike
    localparam int KV_NUM_ENTRIES = 8;
    localparam int KV_ENTRY_W = $clog2(KV_NUM_ENTRIES);

    // dword slots in one entry
    // a client result must fit, DATA_WIDTH/32 <= this
    localparam int KV_ENTRY_DWORDS = 16;
    localparam int KV_OFFSET_W = $clog2(KV_ENTRY_DWORDS);

    // destination-valid bits kept per entry
    localparam int KV_NUM_DEST = 6;

    // whatever is left of the control word above the fields
    localparam int KV_CTRL_RSVD_W = 32 - 1 - KV_ENTRY_W - 1 - KV_NUM_DEST;

    // client control word
    // software writes raw, the client reads fld
    // layout from bit 0 up:
    //   [0]     write_en, self clearing on done
    //   [3:1]   write_entry
    //   [4]     entry_is_pcr, picks the pcr bank
    //   [10:5]  write_dest_vld
    //   [31:11] reserved
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [KV_CTRL_RSVD_W-1:0] rsvd;
            logic [KV_NUM_DEST-1:0]    write_dest_vld;
            logic                      entry_is_pcr;
            logic [KV_ENTRY_W-1:0]     write_entry;
            logic                      write_en;
        } fld;
    } kv_write_ctrl_reg_u;

endpackage

`default_nettype wire
